/* include/rv_mini_params.svh */
// Memory map of the RV32I-subset subsystem, all byte addresses
// Memory depth must stay a power of two, word accesses only
`ifndef RV_MINI_PARAMS_SVH
`define RV_MINI_PARAMS_SVH

// --------------------------------------------------
// Storage
// --------------------------------------------------
// 32-bit words in the shared array, 4 KB
`define RV_MEM_WORDS 1024

// --------------------------------------------------
// Program layout
// --------------------------------------------------
// First fetch after reset
`define RV_RESET_PC 32'h0000_0000
// Argument word, read by the program with LW
`define RV_ARG_ADDR 32'h0000_03A0
// Result word, word 240
`define RV_RESULT_ADDR 32'h0000_03C0

`endif

/* hw/rv_mini_pkg.sv */
// Shared types for the RV32I-subset core
// Only the opcodes and function codes of the executed subset are named
package rv_mini_pkg;

    // Data and byte address word
    typedef logic [31:0] word_t;

    // --------------------------------------------------
    // Major opcodes, instruction bits 6:0
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // funct3 of OP_IMM, OP, LOAD and STORE
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_WORD = 3'b010
    } funct3_op_e;

    // funct3 of BRANCH
    typedef enum logic [2:0] {
        F3_BNE = 3'b001,
        F3_BLT = 3'b100
    } funct3_br_e;

    // --------------------------------------------------
    // One instruction word, two field layouts
    // --------------------------------------------------
    // I-type, also used for JAL immediate bits
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } instr_i_t;

    // S/B-type, imm_hi doubles as funct7 for OP
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        opcode_e     opcode;
    } instr_s_t;

    typedef union packed {
        instr_i_t i;
        instr_s_t s;
    } instr_u;

endpackage

/* hw/rv_mini_fetch.sv */
// One fetch in flight at a time; the PC only moves on instr_done
// A request already issued completes even if run falls meanwhile
`include "rv_mini_params.svh"

module rv_mini_fetch import rv_mini_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   run,
    input  logic   halted,
    input  logic   instr_done,
    input  word_t  next_pc,
    output logic   instr_req,
    output word_t  instr_addr,
    input  logic   instr_gnt,
    input  word_t  rdata,
    output logic   instr_valid,
    output instr_u instr_word,
    output word_t  instr_pc
);

    word_t pc;

    // --------------------------------------------------
    // Control: idle -> request -> valid -> idle
    // --------------------------------------------------
    // instr_req and instr_valid double as the state bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RV_RESET_PC;
            instr_req   <= 1'b0;
            instr_valid <= 1'b0;
        end else if (instr_valid) begin
            // Hold the word until execute retires it
            if (instr_done) begin
                instr_valid <= 1'b0;
                pc          <= next_pc;
            end
        end else if (instr_req) begin
            // Read data arrives with the grant
            if (instr_gnt) begin
                instr_req   <= 1'b0;
                instr_valid <= 1'b1;
            end
        end else if (run && !halted) begin
            instr_req <= 1'b1;
        end
    end

    // Instruction capture, payload only
    always_ff @(posedge clk) begin
        if (instr_req && instr_gnt) begin
            instr_word <= rdata;
        end
    end

    // PC is stable from request until retire
    assign instr_addr = pc;
    assign instr_pc   = pc;

endmodule

/* hw/rv_mini_exec.sv */
// Multi-cycle execute for ADDI SLLI ADD LW SW BNE BLT JAL
// Unknown opcodes and non-word loads/stores retire as no-ops
module rv_mini_exec import rv_mini_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   instr_valid,
    input  instr_u instr_word,
    input  word_t  instr_pc,
    output logic   instr_done,
    output word_t  next_pc,
    output logic   halted,
    output logic   data_rd_req,
    output logic   data_wr_req,
    output word_t  data_addr,
    output word_t  data_wdata,
    input  logic   data_gnt,
    input  word_t  rdata
);

    // Sequencer states
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_MEM  = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0] state;
    word_t      regs [32];
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    logic       wb_en;
    word_t      wb_data;
    word_t      target;
    word_t      mem_addr;
    logic       is_load;
    logic       is_store;
    logic       is_halt;
    logic       issue;

    // --------------------------------------------------
    // Operands and immediates
    // --------------------------------------------------
    // x0 reads zero, its storage is never written
    assign rs1_val = (instr_word.i.rs1 == 5'd0) ? '0 : regs[instr_word.i.rs1];
    assign rs2_val = (instr_word.s.rs2 == 5'd0) ? '0 : regs[instr_word.s.rs2];

    assign imm_i = {{20{instr_word.i.imm[11]}}, instr_word.i.imm};
    assign imm_s = {{20{instr_word.s.imm_hi[6]}}, instr_word.s.imm_hi, instr_word.s.imm_lo};
    // B-type bits scattered over both halves of the s view
    assign imm_b = {{20{instr_word.s.imm_hi[6]}}, instr_word.s.imm_lo[0],
                    instr_word.s.imm_hi[5:0], instr_word.s.imm_lo[4:1], 1'b0};
    // J-type rebuilt from the i view, bits 19:12 sit in rs1/funct3
    assign imm_j = {{12{instr_word.i.imm[11]}}, instr_word.i.rs1, instr_word.i.funct3,
                    instr_word.i.imm[0], instr_word.i.imm[10:1], 1'b0};

    // New instruction seen by the sequencer this cycle
    assign issue = (state == S_IDLE) && instr_valid && !halted;

    // --------------------------------------------------
    // Decode, ALU and branch resolve
    // --------------------------------------------------
    always_comb begin
        wb_en    = 1'b0;
        wb_data  = rs1_val + imm_i;
        target   = instr_pc + 32'd4;
        mem_addr = rs1_val + imm_i;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_halt  = 1'b0;
        case (instr_word.i.opcode)
            OP_IMM: begin
                if (instr_word.i.funct3 == F3_ADD) begin
                    wb_en = 1'b1;
                end else if (instr_word.i.funct3 == F3_SLL && instr_word.i.imm[11:5] == 7'd0) begin
                    wb_en   = 1'b1;
                    wb_data = rs1_val << instr_word.i.imm[4:0];
                end
            end
            OP: begin
                // ADD only, funct7 must be zero
                if (instr_word.s.funct3 == F3_ADD && instr_word.s.imm_hi == 7'd0) begin
                    wb_en   = 1'b1;
                    wb_data = rs1_val + rs2_val;
                end
            end
            LOAD: begin
                is_load = (instr_word.i.funct3 == F3_WORD);
            end
            STORE: begin
                is_store = (instr_word.s.funct3 == F3_WORD);
                mem_addr = rs1_val + imm_s;
            end
            BRANCH: begin
                if ((instr_word.s.funct3 == F3_BNE && rs1_val != rs2_val) ||
                    (instr_word.s.funct3 == F3_BLT && $signed(rs1_val) < $signed(rs2_val))) begin
                    target = instr_pc + imm_b;
                end
            end
            JAL: begin
                wb_en   = 1'b1;
                wb_data = instr_pc + 32'd4;
                target  = instr_pc + imm_j;
                // j . marks program end
                is_halt = (imm_j == '0) && (instr_word.i.rd == 5'd0);
            end
            default: begin
            end
        endcase
    end

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            instr_done  <= 1'b0;
            halted      <= 1'b0;
            data_rd_req <= 1'b0;
            data_wr_req <= 1'b0;
        end else begin
            instr_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (issue && (is_load || is_store)) begin
                        data_rd_req <= is_load;
                        data_wr_req <= is_store;
                        state       <= S_MEM;
                    end else if (issue) begin
                        instr_done <= 1'b1;
                        state      <= S_DONE;
                        // Sticky until reset
                        if (is_halt) begin
                            halted <= 1'b1;
                        end
                    end
                end
                S_MEM: begin
                    // Request held until the grant
                    if (data_gnt) begin
                        data_rd_req <= 1'b0;
                        data_wr_req <= 1'b0;
                        instr_done  <= 1'b1;
                        state       <= S_DONE;
                    end
                end
                default: begin
                    // Fetch drops instr_valid on the done pulse
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Address, store data and next PC latched at issue
    always_ff @(posedge clk) begin
        if (issue) begin
            data_addr  <= mem_addr;
            data_wdata <= rs2_val;
            next_pc    <= target;
        end
    end

    // Register file write port, ALU result or load data
    always_ff @(posedge clk) begin
        if (issue && wb_en && instr_word.i.rd != 5'd0) begin
            regs[instr_word.i.rd] <= wb_data;
        end else if (state == S_MEM && data_gnt && data_rd_req && instr_word.i.rd != 5'd0) begin
            regs[instr_word.i.rd] <= rdata;
        end
    end

endmodule

/* hw/rv_mini_mem_arb.sv */
// Fixed priority host > data > instruction, one access per cycle
// Host is served only while run is low, cores only while run is high
`include "rv_mini_params.svh"

module rv_mini_mem_arb import rv_mini_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  host_en,
    input  logic  host_we,
    input  word_t host_addr,
    input  word_t host_wdata,
    output word_t host_rdata,
    input  logic  instr_req,
    input  word_t instr_addr,
    output logic  instr_gnt,
    input  logic  data_rd_req,
    input  logic  data_wr_req,
    input  word_t data_addr,
    input  word_t data_wdata,
    output logic  data_gnt,
    output word_t rdata
);

    // Word address width
    localparam int AW = $clog2(`RV_MEM_WORDS);

    word_t         mem [`RV_MEM_WORDS];
    word_t         mem_q;
    logic          host_sel;
    logic          data_sel;
    logic          instr_sel;
    logic          host_gnt;
    logic          mem_en;
    logic          mem_we;
    logic [AW-1:0] mem_addr;
    word_t         mem_wdata;

    // --------------------------------------------------
    // Request selection
    // --------------------------------------------------
    // A requester still high in its grant cycle is not taken again
    always_comb begin
        host_sel  = !run && host_en;
        data_sel  = run && (data_rd_req || data_wr_req) && !data_gnt;
        instr_sel = run && instr_req && !instr_gnt && !data_sel;
        mem_en    = host_sel || data_sel || instr_sel;

        mem_we    = 1'b0;
        mem_wdata = data_wdata;
        mem_addr  = instr_addr[AW+1:2];
        if (host_sel) begin
            mem_we    = host_we;
            mem_wdata = host_wdata;
            mem_addr  = host_addr[AW+1:2];
        end else if (data_sel) begin
            mem_we    = data_wr_req;
            mem_addr  = data_addr[AW+1:2];
        end
    end

    // --------------------------------------------------
    // Grants, one cycle after acceptance
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_gnt  <= 1'b0;
            data_gnt  <= 1'b0;
            instr_gnt <= 1'b0;
        end else begin
            host_gnt  <= host_sel;
            data_gnt  <= data_sel;
            instr_gnt <= instr_sel;
        end
    end

    // --------------------------------------------------
    // Single-port word array
    // --------------------------------------------------
    // Read before write on the same address
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end
            mem_q <= mem[mem_addr];
        end
    end

    // Cores qualify read data with their own grant
    assign rdata = mem_q;

    // Host sees zero outside its read cycle
    assign host_rdata = host_gnt ? mem_q : '0;

endmodule

/* hw/rv_mini_top.sv */
// RV32I-subset core and its shared memory behind one host port
// Load program and argument with run low, then raise run until halted
module rv_mini_top import rv_mini_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  host_en,
    input  logic  host_we,
    input  word_t host_addr,
    input  word_t host_wdata,
    output word_t host_rdata,
    output logic  halted
);

    // Fetch to execute
    logic   instr_valid;
    instr_u instr_word;
    word_t  instr_pc;
    logic   instr_done;
    word_t  next_pc;

    // Cores to memory
    logic   instr_req;
    word_t  instr_addr;
    logic   instr_gnt;
    logic   data_rd_req;
    logic   data_wr_req;
    word_t  data_addr;
    word_t  data_wdata;
    logic   data_gnt;
    word_t  rdata;

    // --------------------------------------------------
    // Input side, instruction fetch
    // --------------------------------------------------
    rv_mini_fetch fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .halted      (halted),
        .instr_done  (instr_done),
        .next_pc     (next_pc),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .instr_gnt   (instr_gnt),
        .rdata       (rdata),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_pc    (instr_pc)
    );

    // Execute with register file
    rv_mini_exec exec_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_pc    (instr_pc),
        .instr_done  (instr_done),
        .next_pc     (next_pc),
        .halted      (halted),
        .data_rd_req (data_rd_req),
        .data_wr_req (data_wr_req),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_gnt    (data_gnt),
        .rdata       (rdata)
    );

    // --------------------------------------------------
    // Output side, arbiter and storage
    // --------------------------------------------------
    rv_mini_mem_arb mem_arb_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .host_en     (host_en),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .instr_gnt   (instr_gnt),
        .data_rd_req (data_rd_req),
        .data_wr_req (data_wr_req),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_gnt    (data_gnt),
        .rdata       (rdata)
    );

endmodule

/* dv/rv_mini_checker.sv */
// Compares host read data one cycle after each host read issued with run low
// Expected word must be driven together with the read request
module rv_mini_checker import rv_mini_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  host_en,
    input  logic  host_we,
    input  word_t host_addr,
    input  word_t host_rdata,
    input  logic  halted,
    input  word_t exp_data,
    output int    check_count,
    output int    error_count
);
    timeunit 1ns;
    timeprecision 1ns;

    // Read accepted last cycle, data due now
    logic  read_pending;
    word_t read_addr;
    word_t read_exp;
    // Previous-cycle copies for edge detection
    logic  rst_q;
    logic  halted_q;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    // --------------------------------------------------
    // Host read data compare
    // --------------------------------------------------
    always @(posedge clk) begin
        if (read_pending) begin
            check_count = check_count + 1;
            if (host_rdata !== read_exp) begin
                error_count = error_count + 1;
                $display("FAILED host_rdata at 0x%08h: got 0x%08h, expected 0x%08h",
                         read_addr, host_rdata, read_exp);
            end
        end

        // First cycle out of reset, halt flag must be clear
        if (rst_n && !rst_q) begin
            check_count = check_count + 1;
            if (halted !== 1'b0) begin
                error_count = error_count + 1;
                $display("FAILED halted after reset: got 0x%0h, expected 0x0", halted);
            end
        end

        // Halt can only come from an instruction, so run must be high
        if (rst_n && rst_q && halted && !halted_q && !run) begin
            error_count = error_count + 1;
            $display("Halt flag rose while the core was stopped");
        end

        // Capture for next cycle
        read_pending = rst_n && !run && host_en && !host_we;
        read_addr    = host_addr;
        read_exp     = exp_data;
        rst_q        = rst_n;
        halted_q     = halted;
    end

endmodule

/* dv/rv_mini_properties.sv */
// Memory handshake and halt flag assertions, bound into the top level
// Grants trail acceptance by one cycle, so run is checked one cycle back
module rv_mini_properties (
    input logic clk,
    input logic rst_n,
    input logic run,
    input logic host_gnt,
    input logic halted,
    input logic instr_req,
    input logic instr_gnt,
    input logic data_rd_req,
    input logic data_wr_req,
    input logic data_gnt
);
    timeunit 1ns;
    timeprecision 1ns;

    // Failed assertions so far, read by the testbench top
    int fail_count = 0;

    // --------------------------------------------------
    // Arbiter
    // --------------------------------------------------
    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({host_gnt, instr_gnt, data_gnt}))
        else begin
            fail_count++;
            $error("more than one memory grant in a cycle");
        end

    instr_gnt_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        instr_gnt |-> $past(instr_req))
        else begin
            fail_count++;
            $error("instruction grant without a request");
        end

    data_gnt_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        data_gnt |-> $past(data_rd_req || data_wr_req))
        else begin
            fail_count++;
            $error("data grant without a request");
        end

    // Access accepted before run fell still completes
    core_gnt_needs_run: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_gnt || data_gnt) |-> $past(run))
        else begin
            fail_count++;
            $error("core grant while run was low");
        end

    // Halt is sticky
    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(halted) |-> $past(!rst_n))
        else begin
            fail_count++;
            $error("halted fell without reset");
        end

endmodule

bind rv_mini_top rv_mini_properties props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .host_gnt    (mem_arb_i.host_gnt),
    .halted      (halted),
    .instr_req   (instr_req),
    .instr_gnt   (instr_gnt),
    .data_rd_req (data_rd_req),
    .data_wr_req (data_wr_req),
    .data_gnt    (data_gnt)
);

/* dv/rv_mini_tb.sv */
// Runs host-loaded loop programs, each from a fresh reset since halted is sticky
// Register file is not reset, programs set every register they read
`include "rv_mini_params.svh"

module rv_mini_tb import rv_mini_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    localparam word_t arg_addr    = `RV_ARG_ADDR;
    localparam word_t result_addr = `RV_RESULT_ADDR;
    localparam int    halt_limit  = 5000;
    // Observation window for the program without a self-jump
    localparam int    loop_window = 300;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  run;
    logic  host_en;
    logic  host_we;
    word_t host_addr;
    word_t host_wdata;
    word_t host_rdata;
    logic  halted;
    word_t exp_data;
    int    check_count;
    int    error_count;
    int    other_errors;
    word_t lcg_state;
    word_t prog[$];

    always #50 clk = ~clk;

    rv_mini_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .host_en    (host_en),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .halted     (halted)
    );

    rv_mini_checker checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .host_en     (host_en),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_rdata  (host_rdata),
        .halted      (halted),
        .exp_data    (exp_data),
        .check_count (check_count),
        .error_count (error_count)
    );

    // --------------------------------------------------
    // RV32I encoders
    // --------------------------------------------------
    function automatic word_t itype(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t addi_instr(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return itype(imm, rs1, 3'b000, rd, 7'h13);
    endfunction

    function automatic word_t slli_instr(input logic [4:0] rd, rs1, input logic [4:0] sh);
        return itype({7'd0, sh}, rs1, 3'b001, rd, 7'h13);
    endfunction

    function automatic word_t lw_instr(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return itype(imm, rs1, 3'b010, rd, 7'h03);
    endfunction

    function automatic word_t add_instr(input logic [4:0] rd, rs1, rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    function automatic word_t sw_instr(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    // B-type offset scatter
    function automatic word_t branch_instr(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
    endfunction

    function automatic word_t bne_instr(input logic [4:0] rs1, rs2, input int off);
        return branch_instr(3'b001, rs1, rs2, off);
    endfunction

    function automatic word_t blt_instr(input logic [4:0] rs1, rs2, input int off);
        return branch_instr(3'b100, rs1, rs2, off);
    endfunction

    // J-type offset scatter, offset 0 with rd x0 is the halt idiom
    function automatic word_t jal_instr(input logic [4:0] rd, input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
    endfunction

    // --------------------------------------------------
    // LCG and expected results
    // --------------------------------------------------
    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t pow2_expected(input int n);
        word_t v;
        v = 32'd1;
        repeat (n) begin
            v = v * 32'd2;
        end
        return v;
    endfunction

    // fib(0) = 0, fib(1) = 1, wraps at 32 bits
    function automatic word_t fib_expected(input int n);
        word_t a;
        word_t b;
        word_t t;
        a = 32'd0;
        b = 32'd1;
        repeat (n) begin
            t = a + b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    // --------------------------------------------------
    // Host port and run control
    // --------------------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        rst_n   <= 1'b0;
        run     <= 1'b0;
        host_en <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        @(posedge clk);
        host_en    <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
    endtask

    task automatic release_host();
        @(posedge clk);
        host_en <= 1'b0;
        host_we <= 1'b0;
    endtask

    // Checker compares two edges after the request
    task automatic read_check(input word_t addr, input word_t expected);
        @(posedge clk);
        host_en   <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= addr;
        exp_data  <= expected;
        @(posedge clk);
        host_en <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_halt(input int limit, output logic seen);
        int count;
        seen  = 1'b0;
        count = 0;
        while (!seen && count < limit) begin
            @(posedge clk);
            seen  = halted;
            count = count + 1;
        end
    endtask

    task automatic load_and_start(input word_t arg);
        int i;
        apply_reset();
        for (i = 0; i < prog.size(); i++) begin
            write_word(i * 4, prog[i]);
        end
        write_word(arg_addr, arg);
        release_host();
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic run_program(input word_t arg, input word_t expected, input string what);
        logic seen;
        load_and_start(arg);
        wait_halt(halt_limit, seen);
        @(posedge clk);
        run <= 1'b0;
        if (seen) begin
            read_check(result_addr, expected);
        end else begin
            other_errors = other_errors + 1;
            $display("Timeout in %s run: halted did not rise within %0d cycles",
                     what, halt_limit);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        word_t addr_list[8];
        word_t data_list[8];
        logic  seen;
        int    k;
        int    n;
        int    assert_errors;
        rst_n        = 1'b0;
        run          = 1'b0;
        host_en      = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        exp_data     = '0;
        other_errors = 0;
        lcg_state    = 32'hbb9b;

        // Host write then read, addresses spread over the whole array
        apply_reset();
        for (k = 0; k < 8; k++) begin
            lcg_state    = lcg_next(lcg_state);
            addr_list[k] = ((k * 127) % `RV_MEM_WORDS) * 4;
            data_list[k] = lcg_state;
            write_word(addr_list[k], data_list[k]);
        end
        release_host();
        for (k = 0; k < 8; k++) begin
            read_check(addr_list[k], data_list[k]);
        end

        // Endless two-instruction loop must not halt
        prog = '{addi_instr(5'd1, 5'd1, 12'd1), jal_instr(5'd0, -4)};
        load_and_start(32'd0);
        wait_halt(loop_window, seen);
        @(posedge clk);
        run <= 1'b0;
        if (seen) begin
            other_errors = other_errors + 1;
            $display("Loop program halted although it has no self-jump");
        end else begin
            $display("Loop program timed out after %0d cycles without halting", loop_window);
        end

        // Writes to x0 are dropped, stored x0 overwrites the nonzero marker
        prog = '{addi_instr(5'd1, 5'd0, 12'd77), sw_instr(5'd1, 5'd0, result_addr[11:0]),
                 addi_instr(5'd0, 5'd0, 12'd123), add_instr(5'd0, 5'd1, 5'd1),
                 sw_instr(5'd0, 5'd0, result_addr[11:0]), jal_instr(5'd0, 0)};
        run_program(32'd0, 32'd0, "x0");

        // Doubler, x2 shifted left n times
        prog = '{lw_instr(5'd1, 5'd0, arg_addr[11:0]), addi_instr(5'd2, 5'd0, 12'd1),
                 addi_instr(5'd3, 5'd0, 12'd0), slli_instr(5'd2, 5'd2, 5'd1),
                 addi_instr(5'd3, 5'd3, 12'd1), blt_instr(5'd3, 5'd1, -8),
                 sw_instr(5'd2, 5'd0, result_addr[11:0]), jal_instr(5'd0, 0)};
        run_program(32'd31, pow2_expected(31), "doubler");
        for (k = 0; k < 3; k++) begin
            lcg_state = lcg_next(lcg_state);
            n = 1 + int'(lcg_state[30:16] % 31);
            run_program(n, pow2_expected(n), "doubler");
        end

        // Fibonacci, x2/x3 hold the running pair
        prog = '{lw_instr(5'd1, 5'd0, arg_addr[11:0]), addi_instr(5'd2, 5'd0, 12'd0),
                 addi_instr(5'd3, 5'd0, 12'd1), addi_instr(5'd4, 5'd0, 12'd0),
                 add_instr(5'd5, 5'd2, 5'd3), addi_instr(5'd2, 5'd3, 12'd0),
                 addi_instr(5'd3, 5'd5, 12'd0), addi_instr(5'd4, 5'd4, 12'd1),
                 bne_instr(5'd4, 5'd1, -16), sw_instr(5'd2, 5'd0, result_addr[11:0]),
                 jal_instr(5'd0, 0)};
        run_program(32'd32, fib_expected(32), "fibonacci");
        for (k = 0; k < 3; k++) begin
            lcg_state = lcg_next(lcg_state);
            n = 1 + int'(lcg_state[30:16] % 32);
            run_program(n, fib_expected(n), "fibonacci");
        end

        repeat (2) @(posedge clk);
        assert_errors = dut_i.props_i.fail_count;
        $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion errors: %0d",
                 check_count, error_count, other_errors, assert_errors);
        if (error_count == 0 && other_errors == 0 && assert_errors == 0 && check_count > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* rv_mini_top.f */
+incdir+include
hw/rv_mini_pkg.sv
hw/rv_mini_fetch.sv
hw/rv_mini_exec.sv
hw/rv_mini_mem_arb.sv
hw/rv_mini_top.sv
dv/rv_mini_checker.sv
dv/rv_mini_properties.sv
dv/rv_mini_tb.sv
